// ==== source/ifetch_consts.svh ====
`ifndef IFETCH_CONSTS_SVH
`define IFETCH_CONSTS_SVH

// cache geometry: four lines of four words
`define IFETCH_INDEX_BITS  2
`define IFETCH_LINE_WORDS  4
`define IFETCH_OFFSET_BITS 4   // byte offset within a line
`define IFETCH_TAG_BITS    26

// equals the decoder buffer depth
`define IFETCH_CREDITS     4

`define IFETCH_RESET_PC    32'h8000_0000

// burst length field, four beats
`define IFETCH_BURST_LEN   3

`endif

// ==== source/ifetch_pkg.sv ====
`include "ifetch_consts.svh"

package ifetch_pkg;

  // fetch address split into cache fields
  typedef struct packed {
    logic [`IFETCH_TAG_BITS-1:0]      tag;
    logic [`IFETCH_INDEX_BITS-1:0]    index;
    logic [`IFETCH_OFFSET_BITS-3:0]   word;
    logic [1:0]                       byte_sel;
  } fetch_fields_t;

  // one word, read either raw or by field
  typedef union packed {
    logic [31:0]    raw;
    fetch_fields_t  f;
  } fetch_addr_u;

  // word 0 sits in the low 32 bits
  typedef logic [`IFETCH_LINE_WORDS-1:0][31:0] line_t;

  typedef enum logic [1:0] {
    CSR_CTRL   = 2'd0,
    CSR_HITS   = 2'd1,
    CSR_MISSES = 2'd2
  } csr_addr_e;

endpackage

// ==== source/refill_if.sv ====
`timescale 1ns/1ns
`include "ifetch_consts.svh"

interface refill_if;
  import ifetch_pkg::*;

  logic                          req;       // one-cycle pulse
  fetch_addr_u                   req_addr;  // line aligned
  logic                          busy;
  logic                          line_we;
  logic [`IFETCH_INDEX_BITS-1:0] line_index;
  logic [`IFETCH_TAG_BITS-1:0]   line_tag;
  line_t                         line_data;

  modport requester (output req, output req_addr, input busy);

  modport refiller (
    input  req, req_addr,
    output busy, line_we, line_index, line_tag, line_data
  );

  modport cache (input line_we, line_index, line_tag, line_data);

endinterface

// ==== source/icache_array.sv ====
`timescale 1ns/1ns
`include "ifetch_consts.svh"

module icache_array (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,
  input  ifetch_pkg::fetch_addr_u  lookup_addr,
  output logic                     lookup_hit,
  output logic [31:0]              lookup_word,
  refill_if.cache                  fill
);
  import ifetch_pkg::*;

  localparam int LINES = 1 << `IFETCH_INDEX_BITS;

  line_t                        data_mem [LINES];
  logic [`IFETCH_TAG_BITS-1:0]  tag_mem  [LINES];
  logic [LINES-1:0]             valid;
  line_t                        sel_line;
  logic [`IFETCH_TAG_BITS-1:0]  sel_tag;

  assign sel_line = data_mem[lookup_addr.f.index];
  assign sel_tag  = tag_mem[lookup_addr.f.index];

  // combinational compare at the indexed line
  assign lookup_hit  = valid[lookup_addr.f.index] && (sel_tag == lookup_addr.f.tag);
  assign lookup_word = sel_line[lookup_addr.f.word];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else begin
      if (flush) begin
        valid <= '0;
      end
      // a fill landing with a flush still counts as valid
      if (fill.line_we) begin
        valid[fill.line_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill.line_we) begin
      data_mem[fill.line_index] <= fill.line_data;
      tag_mem[fill.line_index]  <= fill.line_tag;
    end
  end

endmodule

// ==== source/refill_master.sv ====
`timescale 1ns/1ns
`include "ifetch_consts.svh"

module refill_master (
  input  logic         clock,
  input  logic         reset,
  output logic [31:0]  ar_addr,
  output logic [7:0]   ar_len,
  output logic         ar_valid,
  input  logic         ar_ready,
  output logic         r_ready,
  input  logic [31:0]  r_data,
  input  logic         r_valid,
  input  logic         r_last,
  refill_if.refiller   refill
);
  import ifetch_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ADDR = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;

  logic [1:0]                           state;
  fetch_addr_u                          addr_q;
  logic [`IFETCH_LINE_WORDS-2:0][31:0]  line_buf;  // beats before the last one
  logic                                 beat;
  logic                                 last_beat;

  assign ar_valid = (state == ST_ADDR);
  assign r_ready  = (state == ST_DATA);
  assign ar_len   = 8'(`IFETCH_BURST_LEN);
  assign ar_addr  = {addr_q.f.tag, addr_q.f.index, {`IFETCH_OFFSET_BITS{1'b0}}};

  assign beat      = r_ready && r_valid;
  assign last_beat = beat && r_last;

  assign refill.busy       = (state != ST_IDLE);
  assign refill.line_we    = last_beat;
  assign refill.line_index = addr_q.f.index;
  assign refill.line_tag   = addr_q.f.tag;
  assign refill.line_data  = {r_data, line_buf};  // last beat on top

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (refill.req) begin
            state <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (ar_ready) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (last_beat) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address held stable through the handshake
  always_ff @(posedge clock) begin
    if (state == ST_IDLE && refill.req) begin
      addr_q <= refill.req_addr;
    end
  end

  // beats shift in from the top, lowest word ends at the bottom
  always_ff @(posedge clock) begin
    if (beat) begin
      line_buf <= {r_data, line_buf[`IFETCH_LINE_WORDS-2:1]};
    end
  end

endmodule

// ==== source/fetch_sequencer.sv ====
`timescale 1ns/1ns
`include "ifetch_consts.svh"

module fetch_sequencer (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     redirect_valid,
  input  logic [31:0]              redirect_pc,
  input  logic                     credit_return,
  input  logic                     halt,
  input  logic                     lookup_hit,
  input  logic [31:0]              lookup_word,
  output ifetch_pkg::fetch_addr_u  lookup_addr,
  output logic                     inst_valid,
  output logic [31:0]              inst,
  output logic [31:0]              inst_pc,
  output logic                     inst_misaligned,
  output logic                     hit_pulse,
  output logic                     miss_pulse,
  refill_if.requester              refill
);
  import ifetch_pkg::*;

  localparam int CREDIT_BITS = $clog2(`IFETCH_CREDITS + 1);

  localparam logic [1:0] ST_RUN   = 2'd0;
  localparam logic [1:0] ST_MISAL = 2'd1;  // one flagged item pending
  localparam logic [1:0] ST_STOP  = 2'd2;  // parked until next redirect

  fetch_addr_u             pc;
  fetch_addr_u             line_addr;
  logic [1:0]              state;
  logic [CREDIT_BITS-1:0]  credits;
  logic                    can_issue;
  logic                    lookup_ok;
  logic                    issue_hit;
  logic                    issue_mis;
  logic                    consume;
  logic                    refetch;  // lookup retried after a miss

  assign lookup_addr = pc;

  // redirect cycle issues nothing, so inst_valid is low right after it
  assign can_issue = !halt && (credits != '0) && !redirect_valid;
  assign lookup_ok = (state == ST_RUN) && !refill.busy && can_issue;

  assign issue_hit = lookup_ok && lookup_hit;
  assign issue_mis = (state == ST_MISAL) && can_issue;
  assign consume   = issue_hit || issue_mis;

  assign line_addr.raw   = {pc.raw[31:`IFETCH_OFFSET_BITS], {`IFETCH_OFFSET_BITS{1'b0}}};
  assign refill.req      = lookup_ok && !lookup_hit;
  assign refill.req_addr = line_addr;

  assign hit_pulse  = issue_hit && !refetch;  // the retry after a refill is not a hit
  assign miss_pulse = refill.req;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc.raw          <= `IFETCH_RESET_PC;
      state           <= ST_RUN;
      credits         <= CREDIT_BITS'(`IFETCH_CREDITS);
      inst_valid      <= 1'b0;
      inst_misaligned <= 1'b0;
      refetch         <= 1'b0;
    end else begin
      inst_valid      <= consume;
      inst_misaligned <= issue_mis;
      credits         <= credits - CREDIT_BITS'(consume) + CREDIT_BITS'(credit_return);
      if (refill.req) begin
        refetch <= 1'b1;
      end else if (redirect_valid || issue_hit) begin
        refetch <= 1'b0;
      end
      if (redirect_valid) begin
        pc.raw <= redirect_pc;
        state  <= (redirect_pc[1:0] != 2'b00) ? ST_MISAL : ST_RUN;
      end else if (issue_hit) begin
        pc.raw <= pc.raw + 32'd4;
      end else if (issue_mis) begin
        state <= ST_STOP;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (consume) begin
      inst    <= issue_hit ? lookup_word : 32'd0;  // misaligned item carries no word
      inst_pc <= pc.raw;
    end
  end

endmodule

// ==== source/fetch_csr.sv ====
`timescale 1ns/1ns

module fetch_csr (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   csr_write,
  input  ifetch_pkg::csr_addr_e  csr_addr,
  input  logic [31:0]            csr_wdata,
  output logic [31:0]            csr_rdata,
  input  logic                   hit_pulse,
  input  logic                   miss_pulse,
  output logic                   halt,
  output logic                   flush
);
  import ifetch_pkg::*;

  logic [31:0]  hits;
  logic [31:0]  misses;
  logic         ctrl_write;
  logic         hits_clear;
  logic         misses_clear;

  // a write clears, otherwise count up and stick at all ones
  function automatic logic [31:0] next_count(logic [31:0] count, logic clear, logic inc);
    logic [31:0] result;
    if (clear) begin
      result = '0;
    end else if (inc && (count != '1)) begin
      result = count + 32'd1;
    end else begin
      result = count;
    end
    return result;
  endfunction

  assign ctrl_write   = csr_write && (csr_addr == CSR_CTRL);
  assign hits_clear   = csr_write && (csr_addr == CSR_HITS);
  assign misses_clear = csr_write && (csr_addr == CSR_MISSES);

  always_ff @(posedge clock) begin
    if (reset) begin
      halt   <= 1'b0;
      flush  <= 1'b0;
      hits   <= '0;
      misses <= '0;
    end else begin
      flush  <= ctrl_write && csr_wdata[1];  // self clearing
      hits   <= next_count(hits, hits_clear, hit_pulse);
      misses <= next_count(misses, misses_clear, miss_pulse);
      if (ctrl_write) begin
        halt <= csr_wdata[0];
      end
    end
  end

  always_comb begin
    case (csr_addr)
      CSR_CTRL:   csr_rdata = {30'd0, flush, halt};
      CSR_HITS:   csr_rdata = hits;
      CSR_MISSES: csr_rdata = misses;
      default:    csr_rdata = 32'd0;
    endcase
  end

endmodule

// ==== source/ifetch_top.sv ====
`timescale 1ns/1ns

module ifetch_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   redirect_valid,
  input  logic [31:0]            redirect_pc,
  output logic                   inst_valid,
  output logic [31:0]            inst,
  output logic [31:0]            inst_pc,
  output logic                   inst_misaligned,
  input  logic                   credit_return,
  output logic [31:0]            ar_addr,
  output logic [7:0]             ar_len,
  output logic                   ar_valid,
  input  logic                   ar_ready,
  output logic                   r_ready,
  input  logic [31:0]            r_data,
  input  logic                   r_valid,
  input  logic                   r_last,
  input  logic                   csr_write,
  input  ifetch_pkg::csr_addr_e  csr_addr,
  input  logic [31:0]            csr_wdata,
  output logic [31:0]            csr_rdata
);
  import ifetch_pkg::*;

  fetch_addr_u  lookup_addr;
  logic         lookup_hit;
  logic [31:0]  lookup_word;
  logic         halt;
  logic         flush;
  logic         hit_pulse;
  logic         miss_pulse;

  refill_if refill ();

  fetch_sequencer fetch_sequencer_i (
    .clock           (clock),
    .reset           (reset),
    .redirect_valid  (redirect_valid),
    .redirect_pc     (redirect_pc),
    .credit_return   (credit_return),
    .halt            (halt),
    .lookup_hit      (lookup_hit),
    .lookup_word     (lookup_word),
    .lookup_addr     (lookup_addr),
    .inst_valid      (inst_valid),
    .inst            (inst),
    .inst_pc         (inst_pc),
    .inst_misaligned (inst_misaligned),
    .hit_pulse       (hit_pulse),
    .miss_pulse      (miss_pulse),
    .refill          (refill.requester)
  );

  icache_array icache_array_i (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .lookup_addr (lookup_addr),
    .lookup_hit  (lookup_hit),
    .lookup_word (lookup_word),
    .fill        (refill.cache)
  );

  refill_master refill_master_i (
    .clock    (clock),
    .reset    (reset),
    .ar_addr  (ar_addr),
    .ar_len   (ar_len),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r_ready  (r_ready),
    .r_data   (r_data),
    .r_valid  (r_valid),
    .r_last   (r_last),
    .refill   (refill.refiller)
  );

  fetch_csr fetch_csr_i (
    .clock      (clock),
    .reset      (reset),
    .csr_write  (csr_write),
    .csr_addr   (csr_addr),
    .csr_wdata  (csr_wdata),
    .csr_rdata  (csr_rdata),
    .hit_pulse  (hit_pulse),
    .miss_pulse (miss_pulse),
    .halt       (halt),
    .flush      (flush)
  );

endmodule

// ==== tests/ifetch_properties.sv ====
`timescale 1ns/1ns
`include "ifetch_consts.svh"

module ifetch_properties (
  input logic         clock,
  input logic         reset,
  input logic         ar_valid,
  input logic         ar_ready,
  input logic [31:0]  ar_addr,
  input logic         inst_valid,
  input logic         credit_return,
  input logic         redirect_valid,
  input logic         halt
);

  int unsigned fail_count = 0;  // read by the testbench
  int          outstanding;

  // items sent to the decoder minus credits given back
  always_ff @(posedge clock) begin
    if (reset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(inst_valid) - int'(credit_return);
    end
  end

  ar_stable: assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else begin
      $error("ar_valid or ar_addr changed before ar_ready");
      fail_count++;
    end

  credit_limit: assert property (@(posedge clock) disable iff (reset)
    outstanding <= `IFETCH_CREDITS)
    else begin
      $error("more items outstanding than credits");
      fail_count++;
    end

  redirect_gap: assert property (@(posedge clock) disable iff (reset)
    redirect_valid |=> !inst_valid)
    else begin
      $error("item issued right after a redirect");
      fail_count++;
    end

  // halt blocks issue in its own cycle, so the next one is empty
  halt_quiet: assert property (@(posedge clock) disable iff (reset)
    halt |=> !inst_valid)
    else begin
      $error("item issued while halted");
      fail_count++;
    end

endmodule

bind ifetch_top ifetch_properties properties_i (.*);

// ==== tests/ifetch_tb.sv ====
`timescale 1ns/1ns
`include "ifetch_consts.svh"

module ifetch_tb;
  import ifetch_pkg::*;

  localparam int TOTAL_ITEMS = 32 + 16 + 24 + 4 + 1 + 3 + 4;
  localparam longint TIMEOUT_NS = longint'(TOTAL_ITEMS) * 200 * 20;
  localparam logic [31:0] MASK = 32'h5A5A_0000;

  logic clock = 1'b0, reset = 1'b1;
  logic redirect_valid = 1'b0, credit_return = 1'b0;
  logic [31:0] redirect_pc = '0;
  logic ar_ready = 1'b0, r_valid = 1'b0, r_last = 1'b0;
  logic [31:0] r_data = '0;
  logic csr_write = 1'b0;
  csr_addr_e csr_addr = CSR_CTRL;
  logic [31:0] csr_wdata = '0;
  logic inst_valid, inst_misaligned, ar_valid, r_ready;
  logic [31:0] inst, inst_pc, ar_addr, csr_rdata;
  logic [7:0] ar_len;

  logic [31:0] rx_pc[$], rx_inst[$];
  logic rx_mis[$];
  int unsigned credit_due[$];
  int unsigned cycle = 0, granted = 0, returned = 0;
  int unsigned errors = 0, checks = 0, test_errors;
  bit slow_credits = 1'b0;
  logic [31:0] misses0, hits0, value;

  ifetch_top ifetch_top_i (.*);

  always #10 clock = ~clock;

  // decoder: log items, give credits back after a delay and within the grant
  always @(negedge clock) begin
    cycle++;
    if (!reset && inst_valid) begin
      rx_pc.push_back(inst_pc);
      rx_inst.push_back(inst);
      rx_mis.push_back(inst_misaligned);
      credit_due.push_back(cycle + (slow_credits ? 8 + $urandom % 8 : 1 + $urandom % 6));
    end
    credit_return = 1'b0;
    if (credit_due.size() > 0 && credit_due[0] <= cycle && returned < granted) begin
      void'(credit_due.pop_front());
      credit_return = 1'b1;
      returned++;
    end
  end

  // memory: word is its address xor a mask, handshakes delayed 0 to 3 cycles
  initial begin
    logic [31:0] base;
    forever begin
      @(negedge clock);
      if (ar_valid) begin
        repeat ($urandom % 4) @(negedge clock);
        ar_ready = 1'b1;
        base = ar_addr;
        check_value("ar_len", 32'(ar_len), 32'd3);  // four beats
        @(negedge clock);
        ar_ready = 1'b0;
        for (int b = 0; b < 4; b++) begin
          repeat ($urandom % 4) @(negedge clock);
          r_valid = 1'b1;
          r_data = (base + 32'(4 * b)) ^ MASK;
          r_last = (b == 3);
          check_value("r_ready", 32'(r_ready), 32'd1);
          @(negedge clock);
          r_valid = 1'b0;
          r_last = 1'b0;
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out waiting for items");
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic redirect_to(logic [31:0] target);
    @(negedge clock);
    redirect_valid = 1'b1;
    redirect_pc = target;
    @(negedge clock);
    redirect_valid = 1'b0;
    rx_pc.delete();
    rx_inst.delete();
    rx_mis.delete();
  endtask

  task automatic csr_wr(csr_addr_e addr, logic [31:0] data);
    @(negedge clock);
    csr_write = 1'b1;
    csr_addr = addr;
    csr_wdata = data;
    @(negedge clock);
    csr_write = 1'b0;
  endtask

  task automatic csr_rd(csr_addr_e addr, output logic [31:0] data);
    @(negedge clock);
    csr_addr = addr;
    @(negedge clock);
    data = csr_rdata;
  endtask

  // lets n more items through, then checks a straight run from start
  task automatic expect_run(logic [31:0] start, int n);
    logic [31:0] pc;
    granted += n;
    while (rx_pc.size() < n) @(negedge clock);
    for (int i = 0; i < n; i++) begin
      pc = start + 32'(4 * i);
      check_value("inst_pc", rx_pc.pop_front(), pc);
      check_value("inst", rx_inst.pop_front(), pc ^ MASK);
      check_value("inst_misaligned", 32'(rx_mis.pop_front()), 32'd0);
    end
  endtask

  task automatic expect_quiet();
    repeat (40) @(negedge clock);
    checks++;
    assert (rx_pc.size() == 0) else begin
      $display("item arrived while fetch should be stopped");
      errors++;
    end
  endtask

  task automatic end_test(string name);
    $display("test %-12s %s", name, (errors == test_errors) ? "ok" : "FAILED");
    test_errors = errors;
  endtask

  initial begin
    void'($urandom(10));
    test_errors = 0;
    returned = `IFETCH_CREDITS;  // the DUT holds these from reset
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    expect_run(`IFETCH_RESET_PC, 32);
    end_test("sequential");

    csr_rd(CSR_MISSES, value);
    check_value("misses", value, 32'd8);  // one per line
    csr_rd(CSR_HITS, value);
    check_value("hits", value, 32'd24);  // the other three words of each line
    redirect_to(`IFETCH_RESET_PC + 32'h40);
    expect_run(`IFETCH_RESET_PC + 32'h40, 16);
    csr_rd(CSR_MISSES, value);
    check_value("misses", value, 32'd8);
    csr_rd(CSR_HITS, value);
    check_value("hits", value, 32'd40);
    end_test("accounting");

    slow_credits = 1'b1;
    redirect_to(32'h8000_0100);
    expect_run(32'h8000_0100, 24);
    slow_credits = 1'b0;
    end_test("backpressure");

    redirect_to(32'h8000_0200);
    granted += 4;
    while (!ar_valid) @(negedge clock);
    redirect_to(32'h8000_0300);  // refill of 0x200 still in flight
    granted -= 4;
    expect_run(32'h8000_0300, 4);
    end_test("redirect");

    redirect_to(32'h8000_0302);
    granted += 1;
    while (rx_pc.size() < 1) @(negedge clock);
    check_value("inst_pc", rx_pc.pop_front(), 32'h8000_0302);
    check_value("inst", rx_inst.pop_front(), 32'd0);
    check_value("inst_misaligned", 32'(rx_mis.pop_front()), 32'd1);
    granted += 3;
    expect_quiet();
    redirect_to(32'h8000_0300);
    granted -= 3;
    expect_run(32'h8000_0300, 3);
    end_test("misaligned");

    csr_wr(CSR_CTRL, 32'd1);
    redirect_to(32'h8000_0300);
    granted += 4;
    expect_quiet();
    csr_rd(CSR_MISSES, misses0);
    csr_wr(CSR_CTRL, 32'd3);  // flush while still halted
    csr_wr(CSR_CTRL, 32'd0);
    granted -= 4;
    expect_run(32'h8000_0300, 4);
    csr_rd(CSR_MISSES, value);
    check_value("misses", value, misses0 + 32'd1);
    end_test("halt_flush");

    $display("tests 6, checks %0d, errors %0d, assertion failures %0d",
             checks, errors, ifetch_top_i.properties_i.fail_count);
    if (errors == 0 && ifetch_top_i.properties_i.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+source
source/ifetch_pkg.sv
source/refill_if.sv
source/icache_array.sv
source/refill_master.sv
source/fetch_sequencer.sv
source/fetch_csr.sv
source/ifetch_top.sv
tests/ifetch_properties.sv
tests/ifetch_tb.sv

// ==== Bender.yml ====
package:
  name: ifetch

sources:
  - include_dirs:
      - source
    files:
      - source/ifetch_pkg.sv
      - source/refill_if.sv
      - source/icache_array.sv
      - source/refill_master.sv
      - source/fetch_sequencer.sv
      - source/fetch_csr.sv
      - source/ifetch_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/ifetch_properties.sv
      - tests/ifetch_tb.sv
